// ==== common/ppu_pkg.sv ====
`default_nettype none

package ppu_pkg;

    // sprite memory and secondary slot counts
    localparam int num_sprites = 64;
    localparam int num_slots   = 8;

    // sprites are square, one tile wide and high
    localparam int sprite_size = 8;

    // byte address into primary sprite memory, four bytes per sprite
    localparam int oam_addr_w = 8;

    // pattern byte address is {tile, plane, row}
    localparam int pat_addr_w = 12;

    // scan-line row and pixel column
    localparam int coord_w = 9;

    // attribute byte layout
    // bits 1:0 palette, bit 5 behind background, bit 6 h-flip, bit 7 v-flip
    localparam int attr_pal_lo = 0;
    localparam int attr_prio   = 5;
    localparam int attr_flip_h = 6;
    localparam int attr_flip_v = 7;

    // one sprite as evaluation sees it, y in the top byte
    typedef struct packed {
        logic [7:0] y;
        logic [7:0] tile;
        logic [7:0] attribute;
        logic [7:0] x;
    } sprite_fields_t;

    // the same word as the write port sees it
    // byte offset 0 (y) lands in bytes[3], offset 3 (x) in bytes[0]
    typedef union packed {
        logic [3:0][7:0] bytes;
        sprite_fields_t  fields;
    } sprite_word_u;

endpackage

`default_nettype wire

// ==== common/sprite_slot_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface sprite_slot_if;

    logic       active;
    logic [7:0] x_pos;
    logic [7:0] attribute;
    logic [7:0] bitmap_lo;
    logic [7:0] bitmap_hi;
    // set when this slot holds primary sprite 0
    logic       is_zero;

    modport fill (
        output active,
        output x_pos,
        output attribute,
        output bitmap_lo,
        output bitmap_hi,
        output is_zero
    );

    modport draw (
        input active,
        input x_pos,
        input attribute,
        input bitmap_lo,
        input bitmap_hi,
        input is_zero
    );

endinterface

`default_nettype wire

// ==== sprite_eval/pattern_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module pattern_table (
    input  logic                            clk,
    input  logic                            pat_we,
    input  logic [ppu_pkg::pat_addr_w-1:0]  pat_addr,
    input  logic [7:0]                      pat_data,
    input  logic [ppu_pkg::pat_addr_w-2:0]  rd_addr,
    output logic [7:0]                      rd_lo,
    output logic [7:0]                      rd_hi
);
    import ppu_pkg::*;

    // one array per plane, indexed by {tile, row}
    logic [7:0] mem_lo [2**(pat_addr_w-1)];
    logic [7:0] mem_hi [2**(pat_addr_w-1)];

    logic [pat_addr_w-2:0] wr_row_addr;
    logic                  wr_plane;

    // bit 3 of the byte address picks the plane
    assign wr_row_addr = {pat_addr[pat_addr_w-1:4], pat_addr[2:0]};
    assign wr_plane    = pat_addr[3];

    always_ff @(posedge clk) begin
        if (pat_we && !wr_plane) begin
            mem_lo[wr_row_addr] <= pat_data;
        end
        if (pat_we && wr_plane) begin
            mem_hi[wr_row_addr] <= pat_data;
        end
    end

    // both planes of a tile row come out together
    always_ff @(posedge clk) begin
        rd_lo <= mem_lo[rd_addr];
        rd_hi <= mem_hi[rd_addr];
    end

endmodule

`default_nettype wire

// ==== sprite_eval/sprite_eval.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_eval (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            oam_we,
    input  logic [ppu_pkg::oam_addr_w-1:0]  oam_addr,
    input  logic [7:0]                      oam_data,
    input  logic                            line_start,
    input  logic [ppu_pkg::coord_w-1:0]     row,
    output logic [ppu_pkg::pat_addr_w-2:0]  pat_rd_addr,
    input  logic [7:0]                      pat_rd_lo,
    input  logic [7:0]                      pat_rd_hi,
    output logic                            eval_done,
    output logic                            overflow,
    sprite_slot_if.fill                     slots [ppu_pkg::num_slots-1:0]
);
    import ppu_pkg::*;

    sprite_word_u oam_mem [num_sprites];

    logic                                   scanning;
    logic [$clog2(num_sprites+2)-1:0]       step_cnt;
    logic [$clog2(num_slots+1)-1:0]         fill_cnt;
    logic [coord_w-1:0]                     row_q;

    sprite_word_u                           cur;
    logic [coord_w-1:0]                     row_diff;
    logic [2:0]                             tile_row;
    logic                                   stepping;
    logic                                   in_range;
    logic                                   room;
    logic                                   copy;

    // sprite waiting one cycle for its pattern bytes
    logic                                   pend_valid;
    logic [$clog2(num_slots)-1:0]           pend_slot;
    logic [7:0]                             pend_x;
    logic [7:0]                             pend_attr;
    logic                                   pend_zero;

    // shadow set, only copied to the slots at the end of the scan
    logic [num_slots-1:0]                   sh_active;
    logic [7:0]                             sh_x    [num_slots];
    logic [7:0]                             sh_attr [num_slots];
    logic [7:0]                             sh_lo   [num_slots];
    logic [7:0]                             sh_hi   [num_slots];
    logic [num_slots-1:0]                   sh_zero;

    // write port sees raw bytes
    always_ff @(posedge clk) begin
        if (oam_we) begin
            oam_mem[oam_addr[oam_addr_w-1:2]].bytes[~oam_addr[1:0]] <= oam_data;
        end
    end

    // step k looks at sprite k
    assign cur      = oam_mem[step_cnt[$clog2(num_sprites)-1:0]];
    assign stepping = scanning && (step_cnt < num_sprites);
    assign copy     = scanning && (step_cnt == num_sprites + 1);

    // negative differences wrap to large values and fall out of range
    assign row_diff = row_q - coord_w'(cur.fields.y);
    assign in_range = (row_diff < sprite_size);
    assign room     = (fill_cnt < num_slots);

    assign tile_row = cur.fields.attribute[attr_flip_v] ? 3'd7 - row_diff[2:0]
                                                        : row_diff[2:0];
    assign pat_rd_addr = {cur.fields.tile, tile_row};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scanning   <= 1'b0;
            step_cnt   <= '0;
            fill_cnt   <= '0;
            overflow   <= 1'b0;
            eval_done  <= 1'b0;
            pend_valid <= 1'b0;
            sh_active  <= '0;
        end else begin
            eval_done  <= 1'b0;
            pend_valid <= 1'b0;
            if (line_start) begin
                scanning  <= 1'b1;
                step_cnt  <= '0;
                fill_cnt  <= '0;
                overflow  <= 1'b0;
                sh_active <= '0;
            end else if (scanning) begin
                step_cnt <= step_cnt + 1'b1;
                if (stepping && in_range) begin
                    if (room) begin
                        pend_valid <= 1'b1;
                        fill_cnt   <= fill_cnt + 1'b1;
                    end else begin
                        overflow <= 1'b1;
                    end
                end
                if (pend_valid) begin
                    sh_active[pend_slot] <= 1'b1;
                end
                if (copy) begin
                    scanning  <= 1'b0;
                    eval_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_start) begin
            row_q <= row;
        end
        if (stepping && in_range && room) begin
            pend_slot <= fill_cnt[$clog2(num_slots)-1:0];
            pend_x    <= cur.fields.x;
            pend_attr <= cur.fields.attribute;
            pend_zero <= (step_cnt == 0);
        end
        // pattern bytes arrive the cycle after the address was issued
        if (pend_valid) begin
            sh_x[pend_slot]    <= pend_x;
            sh_attr[pend_slot] <= pend_attr;
            sh_lo[pend_slot]   <= pat_rd_lo;
            sh_hi[pend_slot]   <= pat_rd_hi;
            sh_zero[pend_slot] <= pend_zero;
        end
    end

    for (genvar i = 0; i < num_slots; i++) begin : g_copy
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                slots[i].active <= 1'b0;
            end else if (copy) begin
                slots[i].active <= sh_active[i];
            end
        end

        always_ff @(posedge clk) begin
            if (copy) begin
                slots[i].x_pos     <= sh_x[i];
                slots[i].attribute <= sh_attr[i];
                slots[i].bitmap_lo <= sh_lo[i];
                slots[i].bitmap_hi <= sh_hi[i];
                slots[i].is_zero   <= sh_zero[i];
            end
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        scanning |-> !line_start);

    a_no_oam_write: assert property (@(posedge clk) disable iff (!rst_n)
        scanning |-> !oam_we);

endmodule

`default_nettype wire

// ==== sprite_render/sprite_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_slot (
    input  logic [ppu_pkg::coord_w-1:0] col,
    sprite_slot_if.draw                 spr,
    output logic                        hit,
    output logic [3:0]                  color,
    output logic                        prio,
    output logic                        is_zero
);
    import ppu_pkg::*;

    logic [coord_w-1:0] col_within;
    logic               in_range;
    logic [2:0]         bit_idx;
    logic [1:0]         pix;
    logic [1:0]         pal;

    // column offset inside the sprite, wraps high when left of x_pos
    assign col_within = col - coord_w'(spr.x_pos);
    assign in_range   = (col_within < sprite_size);

    // bit 7 is the leftmost pixel unless flipped
    assign bit_idx = spr.attribute[attr_flip_h] ? col_within[2:0]
                                                : 3'd7 - col_within[2:0];

    assign pix = {spr.bitmap_hi[bit_idx], spr.bitmap_lo[bit_idx]};
    assign pal = spr.attribute[attr_pal_lo +: 2];

    // colour 0 is transparent
    assign hit     = spr.active && in_range && (pix != 2'b00);
    assign color   = {pal, pix};
    assign prio    = spr.attribute[attr_prio];
    assign is_zero = spr.is_zero;

endmodule

`default_nettype wire

// ==== sprite_render/sprite_priority.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_priority (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            pix_valid,
    input  logic [ppu_pkg::num_slots-1:0]   hits,
    input  logic [3:0]                      colors [ppu_pkg::num_slots-1:0],
    input  logic [ppu_pkg::num_slots-1:0]   prios,
    input  logic [ppu_pkg::num_slots-1:0]   zeros,
    output logic                            sp_valid,
    output logic [3:0]                      sp_color_idx,
    output logic                            sp_prio,
    output logic                            sp_zero
);
    import ppu_pkg::*;

    logic [3:0] sel_color;
    logic       sel_prio;
    logic       sel_zero;

    // walk from the top so the lowest hitting slot is the last to write
    always_comb begin
        sel_color = '0;
        sel_prio  = 1'b0;
        sel_zero  = 1'b0;
        for (int i = num_slots - 1; i >= 0; i--) begin
            if (hits[i]) begin
                sel_color = colors[i];
                sel_prio  = prios[i];
                sel_zero  = zeros[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sp_valid <= 1'b0;
        end else begin
            sp_valid <= pix_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            sp_color_idx <= sel_color;
            sp_prio      <= sel_prio;
            sp_zero      <= sel_zero;
        end
    end

    // an opaque slot must come out as an opaque pixel one cycle later
    a_opaque_out: assert property (@(posedge clk) disable iff (!rst_n)
        (pix_valid && |hits) |=> (sp_valid && sp_color_idx[1:0] != 2'b00));

endmodule

`default_nettype wire

// ==== hdl/ppu_sprite_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppu_sprite_top (
    input  logic                            clk,
    input  logic                            rst_n,

    // sprite memory write port
    input  logic                            oam_we,
    input  logic [ppu_pkg::oam_addr_w-1:0]  oam_addr,
    input  logic [7:0]                      oam_data,

    // pattern memory write port
    input  logic                            pat_we,
    input  logic [ppu_pkg::pat_addr_w-1:0]  pat_addr,
    input  logic [7:0]                      pat_data,

    input  logic                            line_start,
    input  logic [ppu_pkg::coord_w-1:0]     row,
    output logic                            eval_done,
    output logic                            overflow,

    input  logic                            pix_valid,
    input  logic [ppu_pkg::coord_w-1:0]     col,
    output logic                            sp_valid,
    output logic [3:0]                      sp_color_idx,
    output logic                            sp_prio,
    output logic                            sp_zero
);
    import ppu_pkg::*;

    logic [pat_addr_w-2:0] pat_rd_addr;
    logic [7:0]            pat_rd_lo;
    logic [7:0]            pat_rd_hi;

    logic [num_slots-1:0]  hits;
    logic [3:0]            colors [num_slots-1:0];
    logic [num_slots-1:0]  prios;
    logic [num_slots-1:0]  zeros;

    sprite_slot_if slot_bus [num_slots-1:0] ();

    pattern_table u_pattern_table (
        .clk      (clk),
        .pat_we   (pat_we),
        .pat_addr (pat_addr),
        .pat_data (pat_data),
        .rd_addr  (pat_rd_addr),
        .rd_lo    (pat_rd_lo),
        .rd_hi    (pat_rd_hi)
    );

    sprite_eval u_sprite_eval (
        .clk         (clk),
        .rst_n       (rst_n),
        .oam_we      (oam_we),
        .oam_addr    (oam_addr),
        .oam_data    (oam_data),
        .line_start  (line_start),
        .row         (row),
        .pat_rd_addr (pat_rd_addr),
        .pat_rd_lo   (pat_rd_lo),
        .pat_rd_hi   (pat_rd_hi),
        .eval_done   (eval_done),
        .overflow    (overflow),
        .slots       (slot_bus)
    );

    for (genvar i = 0; i < num_slots; i++) begin : g_slot
        sprite_slot u_sprite_slot (
            .col     (col),
            .spr     (slot_bus[i]),
            .hit     (hits[i]),
            .color   (colors[i]),
            .prio    (prios[i]),
            .is_zero (zeros[i])
        );
    end

    sprite_priority u_sprite_priority (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_valid    (pix_valid),
        .hits         (hits),
        .colors       (colors),
        .prios        (prios),
        .zeros        (zeros),
        .sp_valid     (sp_valid),
        .sp_color_idx (sp_color_idx),
        .sp_prio      (sp_prio),
        .sp_zero      (sp_zero)
    );

endmodule

`default_nettype wire

// ==== verification/sprite_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_checker (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            oam_we,
    input  logic [ppu_pkg::oam_addr_w-1:0]  oam_addr,
    input  logic [7:0]                      oam_data,
    input  logic                            pat_we,
    input  logic [ppu_pkg::pat_addr_w-1:0]  pat_addr,
    input  logic [7:0]                      pat_data,
    input  logic                            line_start,
    input  logic [ppu_pkg::coord_w-1:0]     row,
    input  logic                            eval_done,
    input  logic                            overflow,
    input  logic                            pix_valid,
    input  logic [ppu_pkg::coord_w-1:0]     col,
    input  logic                            sp_valid,
    input  logic [3:0]                      sp_color_idx,
    input  logic                            sp_prio,
    input  logic                            sp_zero,
    output int                              error_count,
    output int                              pixel_count
);
    import ppu_pkg::*;

    typedef struct packed {
        logic       zero;
        logic [7:0] x;
        logic [7:0] attr;
        logic [7:0] lo;
        logic [7:0] hi;
    } slot_t;

    logic [7:0] oam_m [2**oam_addr_w];
    logic [7:0] pat_m [2**pat_addr_w];

    // selection for the line being scanned, and the one rendering uses
    slot_t next_slots [num_slots];
    int    next_count;
    logic  next_ovf;
    slot_t cur_slots [num_slots];
    int    cur_count;
    logic  cur_ovf;

    int         since_start;
    logic       check_due;
    logic [5:0] exp_pix;
    int         exp_col;

    initial begin
        error_count = 0;
        pixel_count = 0;
        next_count  = 0;
        next_ovf    = 1'b0;
        cur_count   = 0;
        cur_ovf     = 1'b0;
        since_start = -1;
        check_due   = 1'b0;
    end

    function automatic void select_sprites(input int r);
        int d;
        int prow;
        int base;
        next_count = 0;
        next_ovf   = 1'b0;
        for (int k = 0; k < num_sprites; k++) begin
            d = r - int'(oam_m[4*k]);
            if (d >= 0 && d < sprite_size) begin
                if (next_count == num_slots) begin
                    next_ovf = 1'b1;
                end else begin
                    prow = oam_m[4*k+2][attr_flip_v] ? 7 - d : d;
                    base = 16 * int'(oam_m[4*k+1]) + prow;
                    next_slots[next_count] = {k == 0, oam_m[4*k+3], oam_m[4*k+2],
                                              pat_m[base], pat_m[base+8]};
                    next_count++;
                end
            end
        end
    endfunction

    // {zero, prio, palette, colour} of the first opaque sprite at column c
    function automatic logic [5:0] expected_pixel(input int c);
        int         dx;
        int         b;
        logic [1:0] p;
        for (int s = 0; s < cur_count; s++) begin
            dx = c - int'(cur_slots[s].x);
            if (dx >= 0 && dx < sprite_size) begin
                b = cur_slots[s].attr[attr_flip_h] ? dx : 7 - dx;
                p = {cur_slots[s].hi[b], cur_slots[s].lo[b]};
                if (p != 2'b00) begin
                    return {cur_slots[s].zero, cur_slots[s].attr[attr_prio],
                            cur_slots[s].attr[attr_pal_lo +: 2], p};
                end
            end
        end
        return 6'b0;
    endfunction

    always @(posedge clk) begin
        if (rst_n) begin
            if (oam_we) begin
                oam_m[oam_addr] = oam_data;
            end
            if (pat_we) begin
                pat_m[pat_addr] = pat_data;
            end
            if (since_start >= 0) begin
                since_start++;
                if (eval_done === 1'b1) begin
                    if (overflow !== next_ovf) begin
                        $display("mismatch at %0t: overflow %b, expected %b",
                                 $time, overflow, next_ovf);
                        error_count++;
                    end
                    cur_slots   = next_slots;
                    cur_count   = next_count;
                    cur_ovf     = next_ovf;
                    since_start = -1;
                end else if (since_start > 100) begin
                    $display("error at %0t: eval_done did not arrive after line_start", $time);
                    error_count++;
                    since_start = -1;
                end
            end else begin
                if (eval_done !== 1'b0) begin
                    $display("error at %0t: eval_done pulsed with no scan running", $time);
                    error_count++;
                end
                // overflow must hold its value between lines
                if (overflow !== cur_ovf) begin
                    $display("mismatch at %0t: overflow %b between lines, expected %b",
                             $time, overflow, cur_ovf);
                    error_count++;
                end
            end
            if (line_start) begin
                select_sprites(int'(row));
                since_start = 0;
            end
            if (check_due) begin
                pixel_count++;
                if (sp_valid !== 1'b1) begin
                    $display("error at %0t: sp_valid stayed low for col %0d", $time, exp_col);
                    error_count++;
                end else if ({sp_zero, sp_prio, sp_color_idx} !== exp_pix) begin
                    $display("mismatch at %0t: col %0d zero/prio/color %b, expected %b",
                             $time, exp_col, {sp_zero, sp_prio, sp_color_idx}, exp_pix);
                    error_count++;
                end
            end else if (sp_valid !== 1'b0) begin
                $display("error at %0t: sp_valid went high with no pixel requested", $time);
                error_count++;
            end
            check_due = pix_valid;
            if (pix_valid) begin
                exp_pix = expected_pixel(int'(col));
                exp_col = int'(col);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_ppu_sprite.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ppu_sprite;
    import ppu_pkg::*;

    // lines drawn over the whole run
    localparam int total_lines     = 73;
    localparam int watchdog_cycles = total_lines * (66 + 300) + 12000;

    logic                  clk;
    logic                  rst_n;
    logic                  oam_we;
    logic [oam_addr_w-1:0] oam_addr;
    logic [7:0]            oam_data;
    logic                  pat_we;
    logic [pat_addr_w-1:0] pat_addr;
    logic [7:0]            pat_data;
    logic                  line_start;
    logic [coord_w-1:0]    row;
    logic                  eval_done;
    logic                  overflow;
    logic                  pix_valid;
    logic [coord_w-1:0]    col;
    logic                  sp_valid;
    logic [3:0]            sp_color_idx;
    logic                  sp_prio;
    logic                  sp_zero;

    int          error_count;
    int          pixel_count;
    int          errors_before;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] rnd_state;

    ppu_sprite_top uut (.*);

    sprite_checker u_checker (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rnd_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rnd_state = x;
        return x;
    endfunction

    // every driving task starts and ends 1 ns after a rising edge
    task automatic write_oam_byte(input int addr, input logic [7:0] data);
        oam_we   = 1'b1;
        oam_addr = oam_addr_w'(addr);
        oam_data = data;
        @(posedge clk);
        #1;
        oam_we = 1'b0;
    endtask

    task automatic write_pattern(input int addr, input logic [7:0] data);
        pat_we   = 1'b1;
        pat_addr = pat_addr_w'(addr);
        pat_data = data;
        @(posedge clk);
        #1;
        pat_we = 1'b0;
    endtask

    task automatic write_sprite(input int idx, input logic [7:0] y, input logic [7:0] tile,
                                input logic [7:0] attr, input logic [7:0] x);
        write_oam_byte(4 * idx, y);
        write_oam_byte(4 * idx + 1, tile);
        write_oam_byte(4 * idx + 2, attr);
        write_oam_byte(4 * idx + 3, x);
    endtask

    // y of 240 keeps a sprite off every drawn row
    task automatic park_sprites();
        for (int i = 0; i < num_sprites; i++) begin
            write_sprite(i, 8'd240, 8'd0, 8'd0, 8'd0);
        end
    endtask

    task automatic fill_tile(input int tile, input logic [7:0] lo, input logic [7:0] hi);
        for (int r = 0; r < sprite_size; r++) begin
            write_pattern(16 * tile + r, lo);
            write_pattern(16 * tile + 8 + r, hi);
        end
    endtask

    task automatic draw_line(input int r, input int first_col, input int last_col);
        int waited;
        line_start = 1'b1;
        row        = coord_w'(r);
        @(posedge clk);
        #1;
        line_start = 1'b0;
        waited     = 0;
        while (eval_done !== 1'b1 && waited < 200) begin
            @(posedge clk);
            #1;
            waited++;
        end
        for (int c = first_col; c <= last_col; c++) begin
            pix_valid = 1'b1;
            col       = coord_w'(c);
            @(posedge clk);
            #1;
        end
        pix_valid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %0s: passed", name);
        end else begin
            tests_failed++;
            $display("test %0s: failed with %0d errors", name, error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", watchdog_cycles);
        $display("Something failed");
        $finish;
    end

    initial begin
        logic [7:0] attr;
        clk           = 1'b0;
        rst_n         = 1'b0;
        oam_we        = 1'b0;
        oam_addr      = '0;
        oam_data      = '0;
        pat_we        = 1'b0;
        pat_addr      = '0;
        pat_data      = '0;
        line_start    = 1'b0;
        row           = '0;
        pix_valid     = 1'b0;
        col           = '0;
        rnd_state     = 32'd34;
        errors_before = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int a = 0; a < 2**pat_addr_w; a++) begin
            write_pattern(a, 8'(next_random()));
        end
        park_sprites();

        // every flip combination, palette and priority follow the flip bits
        for (int f = 0; f < 4; f++) begin
            attr = {f[1:0], f[0], 3'b000, f[1:0]};
            write_sprite(5, 8'd40, 8'd1, attr, 8'd60);
            for (int r = 40; r < 48; r++) begin
                draw_line(r, 56, 71);
            end
        end
        finish_test("flips");

        // tile 2 has transparent columns, tile 3 shows through them
        fill_tile(2, 8'haa, 8'h00);
        fill_tile(3, 8'hff, 8'h0f);
        write_sprite(2, 8'd80, 8'd2, 8'h01, 8'd100);
        write_sprite(3, 8'd80, 8'd3, 8'h22, 8'd104);
        for (int r = 80; r < 88; r++) begin
            draw_line(r, 96, 115);
        end
        finish_test("overlap");

        write_sprite(0, 8'd120, 8'd2, 8'h43, 8'd50);
        write_sprite(1, 8'd120, 8'd3, 8'h00, 8'd52);
        for (int r = 120; r < 128; r++) begin
            draw_line(r, 44, 63);
        end
        finish_test("sprite zero");

        for (int i = 0; i < 10; i++) begin
            write_sprite(10 + i, 8'd150, 8'(next_random()), 8'(next_random()), 8'(24 * i));
        end
        draw_line(153, 0, 255);
        for (int i = 0; i < 3; i++) begin
            write_sprite(20 + i, 8'd158, 8'(next_random()), 8'(next_random()), 8'(60 * i));
        end
        draw_line(160, 0, 255);
        finish_test("overflow");

        park_sprites();
        draw_line(0, 0, 255);
        draw_line(120, 0, 255);
        draw_line(239, 0, 255);
        finish_test("empty lines");

        for (int n = 0; n < 5; n++) begin
            for (int a = 0; a < 4 * num_sprites; a++) begin
                write_oam_byte(a, 8'(next_random()));
            end
            for (int l = 0; l < 4; l++) begin
                draw_line(int'(next_random() % 240), 0, 255);
            end
        end
        finish_test("random scenes");

        $display("tests passed %0d, failed %0d, pixels checked %0d, errors %0d",
                 tests_passed, tests_failed, pixel_count, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ppu_sprite_top.f ====
common/ppu_pkg.sv
common/sprite_slot_if.sv
sprite_eval/pattern_table.sv
sprite_eval/sprite_eval.sv
sprite_render/sprite_slot.sv
sprite_render/sprite_priority.sv
hdl/ppu_sprite_top.sv
verification/sprite_checker.sv
verification/tb_ppu_sprite.sv
